/* map_pkg.sv */
`default_nettype none

package map_pkg;

  // ######################################################################
  // Register counts
  // ######################################################################

  localparam int NUM_ARCH_REGS  = 16; // Architectural registers.
  localparam int NUM_PHYS_REGS  = 32; // Physical registers.
  localparam int RENAME_WIDTH   = 2;  // Instructions renamed per cycle.
  localparam int COMMIT_WIDTH   = 2;  // Instructions committed per cycle.
  localparam int REPAIR_PACKETS = 4;  // Entries copied per recovery cycle.

  // ######################################################################
  // Tag types
  // ######################################################################

  // Index into the architectural register space.
  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;

  // Physical register tag as held in both map tables.
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;

endpackage

`default_nettype wire

/* arch_map_table.sv */
`timescale 1ns/10ps
`default_nettype none

module arch_map_table #(
  parameter int NUM_ARCH_REGS  = map_pkg::NUM_ARCH_REGS,
  parameter int COMMIT_WIDTH   = map_pkg::COMMIT_WIDTH,
  parameter int REPAIR_PACKETS = map_pkg::REPAIR_PACKETS
) (
  input  logic                    clk,
  input  logic                    reset,

  // Commit write lanes.
  input  logic [COMMIT_WIDTH-1:0] commit_valid_i,
  input  map_pkg::arch_reg_t      commit_areg_i [COMMIT_WIDTH],
  input  map_pkg::phys_reg_t      commit_preg_i [COMMIT_WIDTH],
  output map_pkg::phys_reg_t      stale_preg_o  [COMMIT_WIDTH],

  // Repair read ports.
  input  map_pkg::arch_reg_t      repair_addr_i [REPAIR_PACKETS],
  output map_pkg::phys_reg_t      repair_data_o [REPAIR_PACKETS]
);

  import map_pkg::*;

  phys_reg_t amt_q [NUM_ARCH_REGS]; // Committed mapping.

  // ######################################################################
  // Stale tag lookup
  // ######################################################################

  // A lane's stale tag is the mapping its destination held just before
  // it. An earlier valid lane of the same group that wrote the same
  // register supplies that mapping; the latest such lane is taken.
  always_comb
  begin
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      stale_preg_o[k] = amt_q[commit_areg_i[k]]; // Table as of last edge.
      for (int j = 0; j < k; j++)
      begin
        if (commit_valid_i[j] && (commit_areg_i[j] == commit_areg_i[k]))
        begin
          stale_preg_o[k] = commit_preg_i[j]; // Forward from earlier lane.
        end
      end
    end
  end

  // ######################################################################
  // Repair reads
  // ######################################################################

  always_comb
  begin
    for (int p = 0; p < REPAIR_PACKETS; p++)
    begin
      repair_data_o[p] = amt_q[repair_addr_i[p]];
    end
  end

  // ######################################################################
  // Commit writes
  // ######################################################################

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_ARCH_REGS; i++)
      begin
        amt_q[i] <= phys_reg_t'(i); // Identity mapping.
      end
    end
    else
    begin
      // Lanes in ascending order, so the youngest commit lands last.
      for (int k = 0; k < COMMIT_WIDTH; k++)
      begin
        if (commit_valid_i[k])
        begin
          amt_q[commit_areg_i[k]] <= commit_preg_i[k];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rename_map_table.sv */
`timescale 1ns/10ps
`default_nettype none

module rename_map_table #(
  parameter int NUM_ARCH_REGS  = map_pkg::NUM_ARCH_REGS,
  parameter int RENAME_WIDTH   = map_pkg::RENAME_WIDTH,
  parameter int REPAIR_PACKETS = map_pkg::REPAIR_PACKETS
) (
  input  logic                    clk,
  input  logic                    reset,

  // Rename group.
  input  logic [RENAME_WIDTH-1:0] rename_valid_i,
  input  map_pkg::arch_reg_t      src1_areg_i [RENAME_WIDTH],
  input  map_pkg::arch_reg_t      src2_areg_i [RENAME_WIDTH],
  input  map_pkg::arch_reg_t      dest_areg_i [RENAME_WIDTH],
  input  map_pkg::phys_reg_t      dest_preg_i [RENAME_WIDTH],
  output map_pkg::phys_reg_t      src1_preg_o [RENAME_WIDTH],
  output map_pkg::phys_reg_t      src2_preg_o [RENAME_WIDTH],

  // Repair write packet.
  input  logic                    repair_we_i,
  input  map_pkg::arch_reg_t      repair_base_i,
  input  map_pkg::phys_reg_t      repair_data_i [REPAIR_PACKETS]
);

  import map_pkg::*;

  phys_reg_t rmt_q [NUM_ARCH_REGS]; // Speculative mapping.

  // ######################################################################
  // Source lookup with in-group bypass
  // ######################################################################

  // Each source first reads the table, then looks at the earlier lanes
  // of the group. The latest earlier valid lane naming the same
  // register as its destination overrides the table value.
  always_comb
  begin
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      src1_preg_o[k] = rmt_q[src1_areg_i[k]];
      src2_preg_o[k] = rmt_q[src2_areg_i[k]];
      for (int j = 0; j < k; j++)
      begin
        if (rename_valid_i[j] && (dest_areg_i[j] == src1_areg_i[k]))
        begin
          src1_preg_o[k] = dest_preg_i[j]; // Bypass for source 1.
        end
        if (rename_valid_i[j] && (dest_areg_i[j] == src2_areg_i[k]))
        begin
          src2_preg_o[k] = dest_preg_i[j]; // Bypass for source 2.
        end
      end
    end
  end

  // ######################################################################
  // Table update
  // ######################################################################

  // The top level keeps repair and rename apart in time.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_ARCH_REGS; i++)
      begin
        rmt_q[i] <= phys_reg_t'(i); // Identity mapping.
      end
    end
    else
    begin
      if (repair_we_i)
      begin
        for (int p = 0; p < REPAIR_PACKETS; p++)
        begin
          rmt_q[arch_reg_t'(repair_base_i + p)] <= repair_data_i[p];
        end
      end
      // Ascending lanes so the last lane wins on a shared destination.
      for (int k = 0; k < RENAME_WIDTH; k++)
      begin
        if (rename_valid_i[k])
        begin
          rmt_q[dest_areg_i[k]] <= dest_preg_i[k];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* map_recovery.sv */
`timescale 1ns/10ps
`default_nettype none

module map_recovery #(
  parameter int NUM_ARCH_REGS  = map_pkg::NUM_ARCH_REGS,
  parameter int REPAIR_PACKETS = map_pkg::REPAIR_PACKETS
) (
  input  logic               clk,
  input  logic               reset,

  input  logic               recover_i,
  output logic               busy_o,

  // Read side, towards the architectural table.
  output map_pkg::arch_reg_t repair_addr_o [REPAIR_PACKETS],
  input  map_pkg::phys_reg_t repair_data_i [REPAIR_PACKETS],

  // Write side, towards the speculative table.
  output logic               repair_we_o,
  output map_pkg::arch_reg_t repair_base_o,
  output map_pkg::phys_reg_t repair_data_o [REPAIR_PACKETS]
);

  import map_pkg::*;

  localparam int REPAIR_CYCLES = NUM_ARCH_REGS / REPAIR_PACKETS;
  localparam int CNT_W         = (REPAIR_CYCLES > 1) ? $clog2(REPAIR_CYCLES) : 1;

  logic             busy_q;
  logic [CNT_W-1:0] pkt_cnt_q; // Packet being copied.
  arch_reg_t        base;

  // ######################################################################
  // Sequencer state
  // ######################################################################

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy_q    <= 1'b0;
      pkt_cnt_q <= '0;
    end
    else if (!busy_q)
    begin
      if (recover_i)
      begin
        busy_q    <= 1'b1; // Start at packet 0.
        pkt_cnt_q <= '0;
      end
    end
    else if (pkt_cnt_q == CNT_W'(REPAIR_CYCLES - 1))
    begin
      busy_q    <= 1'b0; // Last packet written this edge.
      pkt_cnt_q <= '0;
    end
    else
    begin
      pkt_cnt_q <= pkt_cnt_q + 1'b1;
    end
  end

  // ######################################################################
  // Packet addressing and data
  // ######################################################################

  assign base = arch_reg_t'(pkt_cnt_q * REPAIR_PACKETS);

  always_comb
  begin
    for (int p = 0; p < REPAIR_PACKETS; p++)
    begin
      repair_addr_o[p] = arch_reg_t'(base + p); // Consecutive entries.
      repair_data_o[p] = repair_data_i[p];
    end
  end

  assign repair_base_o = base;
  assign repair_we_o   = busy_q; // One packet per busy cycle.
  assign busy_o        = busy_q;

endmodule

`default_nettype wire

/* map_table_top.sv */
`timescale 1ns/10ps
`default_nettype none

module map_table_top #(
  parameter int NUM_ARCH_REGS  = map_pkg::NUM_ARCH_REGS,
  parameter int NUM_PHYS_REGS  = map_pkg::NUM_PHYS_REGS,
  parameter int RENAME_WIDTH   = map_pkg::RENAME_WIDTH,
  parameter int COMMIT_WIDTH   = map_pkg::COMMIT_WIDTH,
  parameter int REPAIR_PACKETS = map_pkg::REPAIR_PACKETS
) (
  input  logic                    clk,
  input  logic                    reset,

  // Rename group and results.
  input  logic [RENAME_WIDTH-1:0] rename_valid_i,
  input  map_pkg::arch_reg_t      src1_areg_i [RENAME_WIDTH],
  input  map_pkg::arch_reg_t      src2_areg_i [RENAME_WIDTH],
  input  map_pkg::arch_reg_t      dest_areg_i [RENAME_WIDTH],
  input  map_pkg::phys_reg_t      dest_preg_i [RENAME_WIDTH],
  output map_pkg::phys_reg_t      src1_preg_o [RENAME_WIDTH],
  output map_pkg::phys_reg_t      src2_preg_o [RENAME_WIDTH],
  output logic                    rename_ready_o,

  // Commit group and freed tags.
  input  logic [COMMIT_WIDTH-1:0] commit_valid_i,
  input  map_pkg::arch_reg_t      commit_areg_i [COMMIT_WIDTH],
  input  map_pkg::phys_reg_t      commit_preg_i [COMMIT_WIDTH],
  output map_pkg::phys_reg_t      freed_preg_o  [COMMIT_WIDTH],
  output logic [COMMIT_WIDTH-1:0] freed_valid_o,

  // Recovery.
  input  logic                    recover_i,
  output logic                    recovery_busy_o
);

  import map_pkg::*;

  logic                    busy;
  logic [RENAME_WIDTH-1:0] rename_valid_gated;
  arch_reg_t               repair_addr  [REPAIR_PACKETS];
  phys_reg_t               repair_rdata [REPAIR_PACKETS];
  phys_reg_t               repair_wdata [REPAIR_PACKETS];
  arch_reg_t               repair_base;
  logic                    repair_we;

  // Configuration limits checked at elaboration.
  if ((NUM_ARCH_REGS % REPAIR_PACKETS) != 0)
  begin : g_bad_packets
    $error("REPAIR_PACKETS must divide NUM_ARCH_REGS");
  end
  if ((NUM_PHYS_REGS < NUM_ARCH_REGS) || (NUM_PHYS_REGS > (2 ** $bits(phys_reg_t))))
  begin : g_bad_phys
    $error("NUM_PHYS_REGS must cover the identity map and fit phys_reg_t");
  end

  // ######################################################################
  // Rename gating
  // ######################################################################

  assign rename_valid_gated = rename_valid_i & {RENAME_WIDTH{~busy}}; // No renames in recovery.
  assign rename_ready_o     = ~busy;
  assign recovery_busy_o    = busy;
  assign freed_valid_o      = commit_valid_i; // Every commit frees its stale tag.

  // ######################################################################
  // Blocks
  // ######################################################################

  rename_map_table #(
    .NUM_ARCH_REGS  (NUM_ARCH_REGS),
    .RENAME_WIDTH   (RENAME_WIDTH),
    .REPAIR_PACKETS (REPAIR_PACKETS)
  ) i_rename_map_table (
    .clk            (clk),
    .reset          (reset),
    .rename_valid_i (rename_valid_gated),
    .src1_areg_i    (src1_areg_i),
    .src2_areg_i    (src2_areg_i),
    .dest_areg_i    (dest_areg_i),
    .dest_preg_i    (dest_preg_i),
    .src1_preg_o    (src1_preg_o),
    .src2_preg_o    (src2_preg_o),
    .repair_we_i    (repair_we),
    .repair_base_i  (repair_base),
    .repair_data_i  (repair_wdata)
  );

  arch_map_table #(
    .NUM_ARCH_REGS  (NUM_ARCH_REGS),
    .COMMIT_WIDTH   (COMMIT_WIDTH),
    .REPAIR_PACKETS (REPAIR_PACKETS)
  ) i_arch_map_table (
    .clk            (clk),
    .reset          (reset),
    .commit_valid_i (commit_valid_i),
    .commit_areg_i  (commit_areg_i),
    .commit_preg_i  (commit_preg_i),
    .stale_preg_o   (freed_preg_o),
    .repair_addr_i  (repair_addr),
    .repair_data_o  (repair_rdata)
  );

  map_recovery #(
    .NUM_ARCH_REGS  (NUM_ARCH_REGS),
    .REPAIR_PACKETS (REPAIR_PACKETS)
  ) i_map_recovery (
    .clk            (clk),
    .reset          (reset),
    .recover_i      (recover_i),
    .busy_o         (busy),
    .repair_addr_o  (repair_addr),
    .repair_data_i  (repair_rdata),
    .repair_we_o    (repair_we),
    .repair_base_o  (repair_base),
    .repair_data_o  (repair_wdata)
  );

endmodule

`default_nettype wire

/* tb_map_table.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_map_table;

  import map_pkg::*;

  localparam int          TIMEOUT_CYCLES = 50;
  localparam logic [31:0] SEED           = 32'h45c59b20;

  typedef enum {OP_REN, OP_COM, OP_REC, OP_IDLE} op_e;

  // Lane fields are packed with lane 1 on the left.
  typedef struct {
    op_e             op;
    logic [1:0]      valid;
    arch_reg_t [1:0] src1;
    arch_reg_t [1:0] src2;
    arch_reg_t [1:0] dest;
    phys_reg_t [1:0] preg;
    bit              rnd;      // Random tags, or junk renames during recovery.
    int              exp_busy; // Busy cycles expected for a recovery.
  } step_t;

  logic                    clk;
  logic                    reset;
  logic [RENAME_WIDTH-1:0] rename_valid;
  arch_reg_t               src1_areg [RENAME_WIDTH];
  arch_reg_t               src2_areg [RENAME_WIDTH];
  arch_reg_t               dest_areg [RENAME_WIDTH];
  phys_reg_t               dest_preg [RENAME_WIDTH];
  phys_reg_t               src1_preg [RENAME_WIDTH];
  phys_reg_t               src2_preg [RENAME_WIDTH];
  logic                    rename_ready;
  logic [COMMIT_WIDTH-1:0] commit_valid;
  arch_reg_t               commit_areg [COMMIT_WIDTH];
  phys_reg_t               commit_preg [COMMIT_WIDTH];
  phys_reg_t               freed_preg  [COMMIT_WIDTH];
  logic [COMMIT_WIDTH-1:0] freed_valid;
  logic                    recover;
  logic                    recovery_busy;

  phys_reg_t   rmt_m [NUM_ARCH_REGS]; // Expected speculative map.
  phys_reg_t   amt_m [NUM_ARCH_REGS]; // Expected committed map.
  step_t       steps [$];
  logic [31:0] rng;
  int          err_cnt;
  int          fail_steps;
  bit          timed_out;

  map_table_top i_dut (
    .clk             (clk),
    .reset           (reset),
    .rename_valid_i  (rename_valid),
    .src1_areg_i     (src1_areg),
    .src2_areg_i     (src2_areg),
    .dest_areg_i     (dest_areg),
    .dest_preg_i     (dest_preg),
    .src1_preg_o     (src1_preg),
    .src2_preg_o     (src2_preg),
    .rename_ready_o  (rename_ready),
    .commit_valid_i  (commit_valid),
    .commit_areg_i   (commit_areg),
    .commit_preg_i   (commit_preg),
    .freed_preg_o    (freed_preg),
    .freed_valid_o   (freed_valid),
    .recover_i       (recover),
    .recovery_busy_o (recovery_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  // ######################################################################
  // Helpers
  // ######################################################################

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic phys_reg_t rand_tag();
    rng = xorshift32(rng);
    return phys_reg_t'(rng % 32'(NUM_PHYS_REGS));
  endfunction

  task automatic check_preg(input string name, input phys_reg_t got, input phys_reg_t exp);
    if (got !== exp)
    begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic drive_idle();
    rename_valid = '0;
    commit_valid = '0;
    recover      = 1'b0;
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      src1_areg[k] = '0;
      src2_areg[k] = '0;
      dest_areg[k] = '0;
      dest_preg[k] = '0;
    end
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      commit_areg[k] = '0;
      commit_preg[k] = '0;
    end
  endtask

  task automatic add_step(input op_e op, input logic [1:0] valid, input arch_reg_t [1:0] src1,
                          input arch_reg_t [1:0] src2, input arch_reg_t [1:0] dest,
                          input phys_reg_t [1:0] preg, input bit rnd, input int exp_busy);
    step_t s;
    s.op       = op;
    s.valid    = valid;
    s.src1     = src1;
    s.src2     = src2;
    s.dest     = dest;
    s.preg     = preg;
    s.rnd      = rnd;
    s.exp_busy = exp_busy;
    steps.push_back(s);
  endtask

  // ######################################################################
  // Step handlers entered just after a falling edge
  // ######################################################################

  task automatic run_rename(input step_t s);
    phys_reg_t tag [2];
    phys_reg_t e1;
    phys_reg_t e2;
    drive_idle();
    for (int k = 0; k < 2; k++)
    begin
      tag[k]       = s.rnd ? rand_tag() : s.preg[k];
      rename_valid[k] = s.valid[k];
      src1_areg[k] = s.src1[k];
      src2_areg[k] = s.src2[k];
      dest_areg[k] = s.dest[k];
      dest_preg[k] = tag[k];
    end
    #1;
    check_flag("rename_ready_o", rename_ready, 1'b1);
    for (int k = 0; k < 2; k++)
    begin
      e1 = rmt_m[s.src1[k]];
      e2 = rmt_m[s.src2[k]];
      for (int j = 0; j < k; j++)
      begin
        if (s.valid[j] && (s.dest[j] == s.src1[k]))
          e1 = tag[j]; // Same-group producer.
        if (s.valid[j] && (s.dest[j] == s.src2[k]))
          e2 = tag[j];
      end
      check_preg($sformatf("src1_preg_o[%0d]", k), src1_preg[k], e1);
      check_preg($sformatf("src2_preg_o[%0d]", k), src2_preg[k], e2);
    end
    for (int k = 0; k < 2; k++)
      if (s.valid[k])
        rmt_m[s.dest[k]] = tag[k]; // Later lane lands last.
  endtask

  task automatic run_commit(input step_t s);
    phys_reg_t tag [2];
    phys_reg_t ef;
    drive_idle();
    for (int k = 0; k < 2; k++)
    begin
      tag[k]          = s.rnd ? rand_tag() : s.preg[k];
      commit_valid[k] = s.valid[k];
      commit_areg[k]  = s.dest[k];
      commit_preg[k]  = tag[k];
    end
    #1;
    for (int k = 0; k < 2; k++)
    begin
      ef = amt_m[s.dest[k]];
      for (int j = 0; j < k; j++)
        if (s.valid[j] && (s.dest[j] == s.dest[k]))
          ef = tag[j];
      check_preg($sformatf("freed_preg_o[%0d]", k), freed_preg[k], ef);
      check_flag($sformatf("freed_valid_o[%0d]", k), freed_valid[k], s.valid[k]);
    end
    for (int k = 0; k < 2; k++)
      if (s.valid[k])
        amt_m[s.dest[k]] = tag[k];
  endtask

  task automatic run_recover(input step_t s);
    int  busy_cycles;
    int  waited;
    bit  done;
    drive_idle();
    check_flag("recovery_busy_o", recovery_busy, 1'b0);
    recover     = 1'b1;
    busy_cycles = 0;
    waited      = 0;
    done        = 0;
    @(posedge clk);
    while (!done)
    begin
      @(negedge clk);
      if (recovery_busy)
      begin
        busy_cycles++;
        check_flag("rename_ready_o", rename_ready, 1'b0);
        recover = s.rnd; // A held pulse must not restart the copy.
        if (s.rnd)
        begin
          rename_valid = '1;
          for (int k = 0; k < 2; k++)
          begin
            src1_areg[k] = arch_reg_t'(rand_tag());
            dest_areg[k] = arch_reg_t'(rand_tag());
            dest_preg[k] = rand_tag();
          end
        end
      end
      else
        done = 1;
      waited++;
      if (!done && (waited > TIMEOUT_CYCLES))
      begin
        $display("Recovery busy did not fall within %0d cycles", TIMEOUT_CYCLES);
        timed_out = 1;
        err_cnt++;
        done      = 1;
      end
    end
    drive_idle();
    if (busy_cycles != s.exp_busy)
    begin
      $display("Recovery stayed busy for %0d cycles instead of %0d", busy_cycles, s.exp_busy);
      err_cnt++;
    end
    for (int i = 0; i < NUM_ARCH_REGS; i++)
      rmt_m[i] = amt_m[i]; // Speculative map follows the committed one.
  endtask

  // Idle cycles sweep every source lookup over the whole map.
  task automatic run_idle();
    drive_idle();
    check_flag("recovery_busy_o", recovery_busy, 1'b0);
    check_flag("rename_ready_o", rename_ready, 1'b1);
    for (int b = 0; b < NUM_ARCH_REGS; b += 4)
    begin
      if (b != 0)
        @(negedge clk);
      src1_areg[0] = arch_reg_t'(b);
      src1_areg[1] = arch_reg_t'(b + 1);
      src2_areg[0] = arch_reg_t'(b + 2);
      src2_areg[1] = arch_reg_t'(b + 3);
      #1;
      for (int k = 0; k < 2; k++)
      begin
        check_preg($sformatf("src1_preg_o[%0d]", k), src1_preg[k], rmt_m[src1_areg[k]]);
        check_preg($sformatf("src2_preg_o[%0d]", k), src2_preg[k], rmt_m[src2_areg[k]]);
      end
    end
  endtask

  // ######################################################################
  // Stimulus table and main sequence
  // ######################################################################

  task automatic build_table();
    add_step(OP_IDLE, 2'b00, '0, '0, '0, '0, 0, 0);
    add_step(OP_REN, 2'b11, {4'd3, 4'd1}, {4'd5, 4'd2}, {4'd5, 4'd3}, {5'd17, 5'd16}, 0, 0);
    add_step(OP_REN, 2'b11, {4'd7, 4'd5}, {4'd3, 4'd3}, {4'd7, 4'd7}, {5'd19, 5'd18}, 0, 0);
    add_step(OP_REN, 2'b01, {4'd7, 4'd7}, {4'd5, 4'd3}, {4'd0, 4'd8}, {5'd21, 5'd20}, 0, 0);
    add_step(OP_IDLE, 2'b00, '0, '0, '0, '0, 0, 0);
    add_step(OP_COM, 2'b11, '0, '0, {4'd5, 4'd3}, {5'd17, 5'd16}, 0, 0);
    add_step(OP_COM, 2'b11, '0, '0, {4'd7, 4'd7}, {5'd19, 5'd18}, 0, 0);
    add_step(OP_REN, 2'b11, {4'd9, 4'd8}, {4'd10, 4'd8}, {4'd10, 4'd9}, '0, 1, 0);
    add_step(OP_REN, 2'b11, {4'd10, 4'd9}, {4'd2, 4'd1}, {4'd9, 4'd9}, '0, 1, 0);
    add_step(OP_COM, 2'b10, '0, '0, {4'd12, 4'd12}, '0, 1, 0);
    add_step(OP_REC, 2'b00, '0, '0, '0, '0, 0, 4);
    add_step(OP_IDLE, 2'b00, '0, '0, '0, '0, 0, 0);
    add_step(OP_REN, 2'b11, {4'd1, 4'd0}, {4'd3, 4'd2}, {4'd3, 4'd2}, '0, 1, 0);
    add_step(OP_REN, 2'b11, {4'd2, 4'd3}, {4'd4, 4'd5}, {4'd15, 4'd14}, '0, 1, 0);
    add_step(OP_REC, 2'b00, '0, '0, '0, '0, 1, 4);
    add_step(OP_IDLE, 2'b00, '0, '0, '0, '0, 0, 0);
    add_step(OP_COM, 2'b11, '0, '0, {4'd14, 4'd2}, '0, 1, 0);
    add_step(OP_REN, 2'b11, {4'd14, 4'd2}, {4'd15, 4'd3}, {4'd2, 4'd14}, '0, 1, 0);
    add_step(OP_IDLE, 2'b00, '0, '0, '0, '0, 0, 0);
  endtask

  initial
  begin
    int err_before;
    drive_idle();
    reset      = 1'b1;
    rng        = SEED;
    err_cnt    = 0;
    fail_steps = 0;
    timed_out  = 0;
    for (int i = 0; i < NUM_ARCH_REGS; i++)
    begin
      rmt_m[i] = phys_reg_t'(i); // Identity after reset.
      amt_m[i] = phys_reg_t'(i);
    end
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; (i < steps.size()) && !timed_out; i++)
    begin
      @(negedge clk);
      err_before = err_cnt;
      case (steps[i].op)
        OP_REN:  run_rename(steps[i]);
        OP_COM:  run_commit(steps[i]);
        OP_REC:  run_recover(steps[i]);
        default: run_idle();
      endcase
      if (err_cnt != err_before)
        fail_steps++;
      $display("Step %0d %s: %s", i, steps[i].op.name(),
               (err_cnt == err_before) ? "ok" : "mismatch");
    end
    @(negedge clk);
    drive_idle();

    $display("Steps %0d, failing steps %0d, errors %0d", steps.size(), fail_steps, err_cnt);
    if ((err_cnt == 0) && !timed_out)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
map_pkg.sv
arch_map_table.sv
rename_map_table.sv
map_recovery.sv
map_table_top.sv
tb_map_table.sv

/* Makefile */
# Verilator build for the rename map tables.

SIM       := verilator
TOP       := tb_map_table
RTL_TOP   := map_table_top
FILELIST  := sim.f
SIMFLAGS  := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The log decides the outcome, a missing pass line counts as failure.
sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
